/* hdl/vdp_bus_pkg.sv */
// Host and copper bus definitions for the VDP register space:
// address and data widths, register address and data types,
// the write source select used by the arbiter,
// and the single internal register write port.

`default_nettype none

package vdp_bus_pkg;

    // 64 registers of 16 bits each
    localparam int ADDR_W = 6;
    localparam int DATA_W = 16;

    typedef logic [ADDR_W-1:0] reg_addr_t;
    typedef logic [DATA_W-1:0] reg_data_t;

    // which source drives the write port in a given cycle
    typedef enum logic [1:0] {
        SRC_NONE    = 2'd0,
        SRC_CPU     = 2'd1,
        SRC_PENDING = 2'd2,
        SRC_COPPER  = 2'd3
    } write_src_e;

    // one write port shared by every layer bank
    // valid is high for a single cycle per write
    typedef struct packed {
        logic      valid;
        reg_addr_t addr;
        reg_data_t data;
    } reg_write_t;

endpackage

`default_nettype wire

/* hdl/vdp_layer_pkg.sv */
// Layer register definitions:
// layer count and address split, register index enum,
// per-layer configuration struct and the array of all layers,
// and address decode helpers shared by the banks and the read mux.

`default_nettype none

package vdp_layer_pkg;

    localparam int NUM_LAYERS = 4;

    // address bits 5..3 pick the layer, bits 2..0 the register
    localparam int LAYER_SEL_W = 3;
    localparam int REG_IDX_W = 3;

    // indices 5 to 7 are reserved
    typedef enum logic [REG_IDX_W-1:0] {
        REG_SCROLL_X  = 3'd0,
        REG_SCROLL_Y  = 3'd1,
        REG_TILE_BASE = 3'd2,
        REG_MAP_BASE  = 3'd3,
        REG_CONTROL   = 3'd4
    } layer_reg_e;

    // control bit 0 enables the layer
    typedef struct packed {
        vdp_bus_pkg::reg_data_t scroll_x;
        vdp_bus_pkg::reg_data_t scroll_y;
        vdp_bus_pkg::reg_data_t tile_base;
        vdp_bus_pkg::reg_data_t map_base;
        vdp_bus_pkg::reg_data_t control;
    } layer_cfg_t;

    typedef layer_cfg_t [NUM_LAYERS-1:0] layer_cfg_array_t;

    function automatic logic [LAYER_SEL_W-1:0] addr_layer(vdp_bus_pkg::reg_addr_t addr);
        return addr[REG_IDX_W +: LAYER_SEL_W];
    endfunction

    function automatic layer_reg_e addr_reg(vdp_bus_pkg::reg_addr_t addr);
        return layer_reg_e'(addr[REG_IDX_W-1:0]);
    endfunction

endpackage

`default_nettype wire

/* hdl/vdp_host_interface.sv */
// Host interface of the VDP register space:
// CPU enable edge detection, CPU/copper write arbitration
// with a one-entry pending copper slot, the ready pulse
// and the registered CPU read address.

`timescale 1ns/1ps
`default_nettype none

module vdp_host_interface (
    input  wire                         clk,
    input  wire                         reset,

    // CPU side, level enables
    input  wire vdp_bus_pkg::reg_addr_t address_in,
    input  wire                         write_en_in,
    input  wire                         read_en_in,
    input  wire vdp_bus_pkg::reg_data_t data_in,

    // copper side, single cycle write pulses
    input  wire                         cop_write_en,
    input  wire vdp_bus_pkg::reg_addr_t cop_write_address,
    input  wire vdp_bus_pkg::reg_data_t cop_write_data,
    output logic                        cop_write_ready,

    output vdp_bus_pkg::reg_write_t     reg_write,
    output vdp_bus_pkg::reg_addr_t      read_addr,
    output logic                        ready
);
    import vdp_bus_pkg::*;

    logic write_en_r;
    logic write_en_d;
    logic read_en_r;
    logic read_en_d;
    reg_addr_t address_r;
    reg_data_t data_r;

    logic cop_en_r;
    reg_addr_t cop_addr_r;
    reg_data_t cop_data_r;

    logic pend_valid;
    reg_addr_t pend_addr;
    reg_data_t pend_data;

    logic cpu_write_edge;
    logic cpu_read_edge;
    write_src_e src;

    logic write_valid_q;
    reg_addr_t write_addr_q;
    reg_data_t write_data_q;

    // enables are sampled twice so a rising edge can be seen
    always_ff @(posedge clk) begin
        if (reset) begin
            write_en_r <= 1'b0;
            write_en_d <= 1'b0;
            read_en_r <= 1'b0;
            read_en_d <= 1'b0;
            cop_en_r <= 1'b0;
        end else begin
            write_en_r <= write_en_in;
            write_en_d <= write_en_r;
            read_en_r <= read_en_in;
            read_en_d <= read_en_r;
            cop_en_r <= cop_write_en;
        end
    end

    always_ff @(posedge clk) begin
        address_r <= address_in;
        data_r <= data_in;
        cop_addr_r <= cop_write_address;
        cop_data_r <= cop_write_data;
    end

    assign cpu_write_edge = write_en_r && !write_en_d;
    assign cpu_read_edge = read_en_r && !read_en_d;

    // CPU wins, then an older buffered copper write, then a fresh one
    always_comb begin
        if (cpu_write_edge) begin
            src = SRC_CPU;
        end else if (pend_valid) begin
            src = SRC_PENDING;
        end else if (cop_en_r) begin
            src = SRC_COPPER;
        end else begin
            src = SRC_NONE;
        end
    end

    // a copper write that can't go out now waits in the slot
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
        end else if (cop_en_r && src != SRC_COPPER) begin
            pend_valid <= 1'b1;
        end else if (src == SRC_PENDING) begin
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cop_en_r && src != SRC_COPPER) begin
            pend_addr <= cop_addr_r;
            pend_data <= cop_data_r;
        end
    end

    assign cop_write_ready = !pend_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            write_valid_q <= 1'b0;
            ready <= 1'b0;
        end else begin
            write_valid_q <= (src != SRC_NONE);
            ready <= cpu_write_edge || cpu_read_edge;
        end
    end

    always_ff @(posedge clk) begin
        case (src)
            SRC_CPU: begin
                write_addr_q <= address_r;
                write_data_q <= data_r;
            end
            SRC_PENDING: begin
                write_addr_q <= pend_addr;
                write_data_q <= pend_data;
            end
            SRC_COPPER: begin
                write_addr_q <= cop_addr_r;
                write_data_q <= cop_data_r;
            end
            default: ;
        endcase
    end

    assign reg_write.valid = write_valid_q;
    assign reg_write.addr = write_addr_q;
    assign reg_write.data = write_data_q;

    // the read address is captured on the first high sample of the
    // enable, so the read mux has its data ready together with ready
    always_ff @(posedge clk) begin
        if (reset) begin
            read_addr <= '0;
        end else if (read_en_in && !read_en_r) begin
            read_addr <= address_in;
        end
    end

    // the copper must respect cop_write_ready or the slot would overflow
    cop_respects_ready: assert property (
        @(posedge clk) disable iff (reset) cop_write_en |-> cop_write_ready
    );

    // the CPU gap between accesses keeps ready a single pulse
    ready_single_pulse: assert property (
        @(posedge clk) disable iff (reset) ready |=> !ready
    );

endmodule

`default_nettype wire

/* hdl/vdp_layer_regs.sv */
// Register bank of one background layer:
// layer select decode, register index decode,
// field writes and reset to zero.

`timescale 1ns/1ps
`default_nettype none

module vdp_layer_regs #(
    parameter int LAYER_INDEX = 0
) (
    input  wire                          clk,
    input  wire                          reset,
    input  wire vdp_bus_pkg::reg_write_t reg_write,
    output vdp_layer_pkg::layer_cfg_t    cfg
);
    import vdp_layer_pkg::*;

    logic layer_hit;
    layer_reg_e reg_idx;

    // only writes whose address bits 5..3 match this bank
    assign layer_hit = reg_write.valid &&
        (addr_layer(reg_write.addr) == LAYER_SEL_W'(LAYER_INDEX));
    assign reg_idx = addr_reg(reg_write.addr);

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg <= '0;
        end else if (layer_hit) begin
            case (reg_idx)
                REG_SCROLL_X: begin
                    cfg.scroll_x <= reg_write.data;
                end
                REG_SCROLL_Y: begin
                    cfg.scroll_y <= reg_write.data;
                end
                REG_TILE_BASE: begin
                    cfg.tile_base <= reg_write.data;
                end
                REG_MAP_BASE: begin
                    cfg.map_base <= reg_write.data;
                end
                REG_CONTROL: begin
                    cfg.control <= reg_write.data;
                end
                // reserved indices are dropped
                default: ;
            endcase
        end
    end

    // the host interface must never issue a write to an undefined address
    write_addr_known: assert property (
        @(posedge clk) disable iff (reset) reg_write.valid |-> !$isunknown(reg_write.addr)
    );

endmodule

`default_nettype wire

/* hdl/vdp_read_mux.sv */
// CPU read path of the register space:
// layer and field select by read address,
// zero for unmapped layers and reserved indices,
// registered read data.

`timescale 1ns/1ps
`default_nettype none

module vdp_read_mux (
    input  wire                                clk,
    input  wire vdp_bus_pkg::reg_addr_t        read_addr,
    input  wire vdp_layer_pkg::layer_cfg_array_t layer_cfg,
    output vdp_bus_pkg::reg_data_t             read_data
);
    import vdp_bus_pkg::*;
    import vdp_layer_pkg::*;

    logic [LAYER_SEL_W-1:0] layer_sel;
    layer_cfg_t sel_cfg;
    reg_data_t sel_data;

    assign layer_sel = addr_layer(read_addr);

    // layers 4 to 7 have no bank behind them
    always_comb begin
        if (layer_sel < NUM_LAYERS) begin
            sel_cfg = layer_cfg[layer_sel];
        end else begin
            sel_cfg = '0;
        end
    end

    always_comb begin
        case (addr_reg(read_addr))
            REG_SCROLL_X:  sel_data = sel_cfg.scroll_x;
            REG_SCROLL_Y:  sel_data = sel_cfg.scroll_y;
            REG_TILE_BASE: sel_data = sel_cfg.tile_base;
            REG_MAP_BASE:  sel_data = sel_cfg.map_base;
            REG_CONTROL:   sel_data = sel_cfg.control;
            default:       sel_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        read_data <= sel_data;
    end

endmodule

`default_nettype wire

/* hdl/vdp_regs_top.sv */
// Top level of the VDP register space:
// host interface, one register bank per layer,
// and the CPU read multiplexer.

`timescale 1ns/1ps
`default_nettype none

module vdp_regs_top (
    input  wire                              clk,
    input  wire                              reset,

    // CPU
    input  wire vdp_bus_pkg::reg_addr_t      address_in,
    input  wire                              write_en_in,
    input  wire vdp_bus_pkg::reg_data_t      data_in,
    input  wire                              read_en_in,
    output wire                              ready,
    output wire vdp_bus_pkg::reg_data_t      read_data,

    // copper
    input  wire                              cop_write_en,
    input  wire vdp_bus_pkg::reg_addr_t      cop_write_address,
    input  wire vdp_bus_pkg::reg_data_t      cop_write_data,
    output wire                              cop_write_ready,

    // display side
    output wire vdp_layer_pkg::layer_cfg_array_t layer_cfg
);
    import vdp_bus_pkg::*;
    import vdp_layer_pkg::*;

    reg_write_t reg_write;
    reg_addr_t read_addr;

    vdp_host_interface u_host (
        .clk               (clk),
        .reset             (reset),
        .address_in        (address_in),
        .write_en_in       (write_en_in),
        .read_en_in        (read_en_in),
        .data_in           (data_in),
        .cop_write_en      (cop_write_en),
        .cop_write_address (cop_write_address),
        .cop_write_data    (cop_write_data),
        .cop_write_ready   (cop_write_ready),
        .reg_write         (reg_write),
        .read_addr         (read_addr),
        .ready             (ready)
    );

    // every bank sees the same write port and keeps its own layer
    for (genvar i = 0; i < NUM_LAYERS; i++) begin : g_layer
        vdp_layer_regs #(
            .LAYER_INDEX (i)
        ) u_layer_regs (
            .clk       (clk),
            .reset     (reset),
            .reg_write (reg_write),
            .cfg       (layer_cfg[i])
        );
    end

    vdp_read_mux u_read_mux (
        .clk       (clk),
        .read_addr (read_addr),
        .layer_cfg (layer_cfg),
        .read_data (read_data)
    );

endmodule

`default_nettype wire

/* tests/vdp_regs_model.svh */
// Reference model of the VDP register space:
// the 64 register values, the one-entry copper slot,
// and the CPU-first order of coinciding writes.

`ifndef VDP_REGS_MODEL_SVH
`define VDP_REGS_MODEL_SVH

reg_data_t model_regs [64];
logic      model_pend_valid;
reg_addr_t model_pend_addr;
reg_data_t model_pend_data;

function automatic void model_reset();
    foreach (model_regs[i]) begin
        model_regs[i] = '0;
    end
    model_pend_valid = 1'b0;
endfunction

// only layers 0 to 3 and indices 0 to 4 hold a value
function automatic void model_write(reg_addr_t addr, reg_data_t data);
    if (addr[5:3] < NUM_LAYERS && addr[2:0] <= 3'd4) begin
        model_regs[addr] = data;
    end
endfunction

function automatic layer_cfg_t model_layer(int layer);
    layer_cfg_t cfg;
    cfg.scroll_x  = model_regs[layer * 8 + 0];
    cfg.scroll_y  = model_regs[layer * 8 + 1];
    cfg.tile_base = model_regs[layer * 8 + 2];
    cfg.map_base  = model_regs[layer * 8 + 3];
    cfg.control   = model_regs[layer * 8 + 4];
    return cfg;
endfunction

// a copper write loses the port to a CPU write edge in the same cycle
function automatic void model_copper(reg_addr_t addr, reg_data_t data, logic cpu_edge);
    if (cpu_edge) begin
        model_pend_valid = 1'b1;
        model_pend_addr = addr;
        model_pend_data = data;
    end else begin
        model_write(addr, data);
    end
endfunction

// the held copper write goes out on the next free cycle
function automatic void model_release();
    if (model_pend_valid) begin
        model_write(model_pend_addr, model_pend_data);
        model_pend_valid = 1'b0;
    end
endfunction

`endif

/* tests/vdp_regs_tb.sv */
// Testbench for the VDP register space:
// clock and reset, random CPU and copper traffic,
// compare tasks against the reference model, cycle timeout.

`timescale 1ns/1ps
`default_nettype none

module vdp_regs_tb;
    import vdp_bus_pkg::*;
    import vdp_layer_pkg::*;

    localparam int NUM_OPS = 400;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 12 + 100;

    logic clk;
    logic reset;
    reg_addr_t address_in;
    logic write_en_in;
    reg_data_t data_in;
    logic read_en_in;
    logic ready;
    reg_data_t read_data;
    logic cop_write_en;
    reg_addr_t cop_write_address;
    reg_data_t cop_write_data;
    logic cop_write_ready;
    layer_cfg_array_t layer_cfg;

    int seed = 32'h4f53;
    int unsigned cycle_count = 0;

    `include "vdp_regs_model.svh"

    vdp_regs_top DUT (
        .clk               (clk),
        .reset             (reset),
        .address_in        (address_in),
        .write_en_in       (write_en_in),
        .data_in           (data_in),
        .read_en_in        (read_en_in),
        .ready             (ready),
        .read_data         (read_data),
        .cop_write_en      (cop_write_en),
        .cop_write_address (cop_write_address),
        .cop_write_data    (cop_write_data),
        .cop_write_ready   (cop_write_ready),
        .layer_cfg         (layer_cfg)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            halt_with_failure();
        end
    end

    task automatic halt_with_failure();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_read_data(string name, reg_data_t actual, reg_data_t expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, actual);
            halt_with_failure();
        end
    endtask

    task automatic check_layer_cfg(string name, layer_cfg_t actual, layer_cfg_t expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, actual);
            halt_with_failure();
        end
    endtask

    task automatic check_ready(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, actual);
            halt_with_failure();
        end
    endtask

    task automatic compare_layers();
        for (int i = 0; i < NUM_LAYERS; i++) begin
            check_layer_cfg($sformatf("layer_cfg[%0d]", i), layer_cfg[i], model_layer(i));
        end
    endtask

    // CPU write edge, with an optional copper pulse in the same cycle
    task automatic cpu_write(reg_addr_t addr, reg_data_t data, logic with_copper,
                             reg_addr_t cop_addr, reg_data_t cop_data);
        @(negedge clk);
        while (!cop_write_ready) begin
            @(negedge clk);
        end
        address_in = addr;
        data_in = data;
        write_en_in = 1'b1;
        cop_write_address = cop_addr;
        cop_write_data = cop_data;
        cop_write_en = with_copper;
        @(negedge clk);
        cop_write_en = 1'b0;
        check_ready("ready", ready, 1'b0);
        @(negedge clk);
        // write port and ready come up together, banks still hold old values
        check_ready("ready", ready, 1'b1);
        compare_layers();
        write_en_in = 1'b0;
        model_write(addr, data);
        if (with_copper) begin
            model_copper(cop_addr, cop_data, 1'b1);
        end
        check_ready("cop_write_ready", cop_write_ready, !model_pend_valid);
        @(negedge clk);
        check_ready("ready", ready, 1'b0);
        compare_layers();
        model_release();
        check_ready("cop_write_ready", cop_write_ready, !model_pend_valid);
        if (with_copper) begin
            @(negedge clk);
            compare_layers();
        end
    endtask

    task automatic copper_write(reg_addr_t addr, reg_data_t data);
        @(negedge clk);
        while (!cop_write_ready) begin
            @(negedge clk);
        end
        cop_write_address = addr;
        cop_write_data = data;
        cop_write_en = 1'b1;
        @(negedge clk);
        cop_write_en = 1'b0;
        @(negedge clk);
        compare_layers();
        model_copper(addr, data, 1'b0);
        check_ready("cop_write_ready", cop_write_ready, !model_pend_valid);
        @(negedge clk);
        check_ready("ready", ready, 1'b0);
        compare_layers();
    endtask

    task automatic cpu_read(reg_addr_t addr);
        string name;
        name = $sformatf("read_data at 0x%h", addr);
        @(negedge clk);
        address_in = addr;
        read_en_in = 1'b1;
        @(negedge clk);
        check_ready("ready", ready, 1'b0);
        @(negedge clk);
        check_ready("ready", ready, 1'b1);
        check_read_data(name, read_data, model_regs[addr]);
        read_en_in = 1'b0;
        @(negedge clk);
        check_ready("ready", ready, 1'b0);
        // data holds until the next read
        check_read_data(name, read_data, model_regs[addr]);
    endtask

    initial begin
        reg_addr_t addr;
        reg_data_t data;
        reg_addr_t cop_addr;
        reg_data_t cop_data;
        int op;

        clk = 1'b0;
        reset = 1'b1;
        address_in = '0;
        write_en_in = 1'b0;
        data_in = '0;
        read_en_in = 1'b0;
        cop_write_en = 1'b0;
        cop_write_address = '0;
        cop_write_data = '0;
        model_reset();

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        compare_layers();
        check_ready("cop_write_ready", cop_write_ready, 1'b1);
        check_ready("ready", ready, 1'b0);

        for (int n = 0; n < NUM_OPS; n++) begin
            op = $unsigned($random(seed)) % 4;
            addr = reg_addr_t'($random(seed));
            data = reg_data_t'($random(seed));
            cop_addr = reg_addr_t'($random(seed));
            cop_data = reg_data_t'($random(seed));
            // same address half the time so the write order is visible
            if (($random(seed) & 1) != 0) begin
                cop_addr = addr;
            end
            case (op)
                0: cpu_write(addr, data, 1'b0, cop_addr, cop_data);
                1: cpu_read(addr);
                2: copper_write(cop_addr, cop_data);
                default: cpu_write(addr, data, 1'b1, cop_addr, cop_data);
            endcase
        end

        // sweep of the whole register space
        for (int a = 0; a < 64; a++) begin
            cpu_read(reg_addr_t'(a));
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+tests
hdl/vdp_bus_pkg.sv
hdl/vdp_layer_pkg.sv
hdl/vdp_host_interface.sv
hdl/vdp_layer_regs.sv
hdl/vdp_read_mux.sv
hdl/vdp_regs_top.sv
tests/vdp_regs_tb.sv

/* Bender.yml */
package:
  name: vdp_regs

sources:
  - files:
      - hdl/vdp_bus_pkg.sv
      - hdl/vdp_layer_pkg.sv
      - hdl/vdp_host_interface.sv
      - hdl/vdp_layer_regs.sv
      - hdl/vdp_read_mux.sv
      - hdl/vdp_regs_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/vdp_regs_tb.sv
